//--- hdl/ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Instruction fields
`define OPC_RTYPE     6'h00
`define FN_ADD        6'h20
`define FN_SUB        6'h22
`define FN_AND        6'h24
`define FN_SLT        6'h2A

// ALU operations
`define ALUOP_ADD     3'b001
`define ALUOP_SUB     3'b010
`define ALUOP_AND     3'b011
`define ALUOP_SLT     3'b111

// Mux selects
`define SRCA_PC       2'b00
`define SRCA_REGA     2'b01
`define SRCB_REGB     2'b00
`define SRCB_FOUR     2'b01
`define SRCB_OFFSET   2'b11
`define WD_ALUOUT     2'b10
`define DST_RD        2'b01
`define PCSRC_ALU     2'b00
`define PCSRC_EXCVEC  2'b11

// Exception causes
`define EXC_INVALID   2'b00
`define EXC_OVERFLOW  2'b01

// Cycles spent reading the instruction
`define FETCH_STEPS   3

`endif

//--- hdl/ctrlPkg.sv
package ctrlPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] muxSel_t;
    typedef logic [1:0] excCause_t;
    typedef logic [1:0] step_t;

    typedef enum logic [2:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSlt,
        clsInvalid
    } instrClass_t;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stWriteback,
        stException
    } ctrlState_t;

    typedef struct packed {
        aluOp_t  aluOp;
        muxSel_t srcA;
        muxSel_t srcB;
    } aluCtrl_t;

    typedef struct packed {
        logic    pcWrite;
        muxSel_t pcSrc;
        logic    memRead;
        logic    irWrite;
        logic    loadAB;
        logic    aluOutWrite;
    } pathCtrl_t;

    typedef struct packed {
        logic    regWrite;
        muxSel_t regDst;
        muxSel_t writeData;
    } regCtrl_t;

    typedef struct packed {
        logic      epcWrite;
        excCause_t exCause;
    } excCtrl_t;

endpackage

//--- hdl/instrDecoder.sv
`include "ctrl_defines.svh"

module instrDecoder (
    input  ctrlPkg::opcode_t     opcode,
    input  ctrlPkg::funct_t      funct,
    output ctrlPkg::instrClass_t instrClass
);

    import ctrlPkg::*;

    // Only R-type arithmetic is supported
    always_comb begin
        instrClass = clsInvalid;
        if (opcode == `OPC_RTYPE) begin
            case (funct)
                `FN_ADD: begin
                    instrClass = clsAdd;
                end
                `FN_SUB: begin
                    instrClass = clsSub;
                end
                `FN_AND: begin
                    instrClass = clsAnd;
                end
                `FN_SLT: begin
                    instrClass = clsSlt;
                end
                default: begin
                    instrClass = clsInvalid;
                end
            endcase
        end
    end

endmodule

//--- hdl/controlSequencer.sv
`include "ctrl_defines.svh"

module controlSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::instrClass_t instrClass,
    input  logic                 overflow,
    output ctrlPkg::ctrlState_t  state,
    output ctrlPkg::step_t       step,
    output ctrlPkg::instrClass_t curClass
);

    import ctrlPkg::*;

    localparam step_t LastFetch = step_t'(`FETCH_STEPS - 1);

    logic trapOverflow;

    // Only ADD and SUB trap, AND and SLT ignore the flag
    assign trapOverflow = overflow && (curClass == clsAdd || curClass == clsSub);

    // Reset parks on the unused fetch step 3, which wraps to step 0 on the next clock
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            step  <= 2'd3;
        end else begin
            case (state)
                stFetch: begin
                    if (step == LastFetch) begin
                        state <= stDecode;
                        step  <= '0;
                    end else begin
                        step <= step + 2'd1;
                    end
                end
                stDecode: begin
                    step <= '0;
                    if (instrClass == clsInvalid) begin
                        state <= stException;
                    end else begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    step <= '0;
                    if (trapOverflow) begin
                        state <= stException;
                    end else begin
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    state <= stFetch;
                    step  <= '0;
                end
                stException: begin
                    if (step == 2'd1) begin
                        state <= stFetch;
                        step  <= '0;
                    end else begin
                        step <= step + 2'd1;
                    end
                end
                default: begin
                    state <= stFetch;
                    step  <= '0;
                end
            endcase
        end
    end

    // Class of the instruction in flight, also tells the encoder the trap cause
    always_ff @(posedge clk) begin
        if (state == stDecode) begin
            curClass <= instrClass;
        end
    end

endmodule

//--- hdl/controlEncoder.sv
`include "ctrl_defines.svh"

module controlEncoder (
    input  ctrlPkg::ctrlState_t  state,
    input  ctrlPkg::step_t       step,
    input  ctrlPkg::instrClass_t curClass,
    output ctrlPkg::aluCtrl_t    aluCtrl,
    output ctrlPkg::pathCtrl_t   pathCtrl,
    output ctrlPkg::regCtrl_t    regCtrl,
    output ctrlPkg::excCtrl_t    excCtrl
);

    import ctrlPkg::*;

    function automatic aluOp_t classOp(input instrClass_t cls);
        aluOp_t op;
        case (cls)
            clsSub: begin
                op = `ALUOP_SUB;
            end
            clsAnd: begin
                op = `ALUOP_AND;
            end
            clsSlt: begin
                op = `ALUOP_SLT;
            end
            default: begin
                op = `ALUOP_ADD;
            end
        endcase
        return op;
    endfunction

    always_comb begin
        aluCtrl  = '0;
        pathCtrl = '0;
        regCtrl  = '0;
        excCtrl  = '0;

        case (state)
            stFetch: begin
                // Step 3 only occurs right after reset and drives nothing
                if (step < step_t'(`FETCH_STEPS)) begin
                    pathCtrl.memRead = 1'b1;
                    pathCtrl.irWrite = 1'b1;
                    aluCtrl.aluOp    = `ALUOP_ADD;
                    aluCtrl.srcA     = `SRCA_PC;
                    aluCtrl.srcB     = `SRCB_FOUR;
                    if (step == '0) begin
                        pathCtrl.pcWrite = 1'b1;
                        pathCtrl.pcSrc   = `PCSRC_ALU;
                    end
                end
            end
            stDecode: begin
                pathCtrl.loadAB      = 1'b1;
                pathCtrl.aluOutWrite = 1'b1;
                // Branch target precompute, PC plus offset
                aluCtrl.aluOp        = `ALUOP_ADD;
                aluCtrl.srcA         = `SRCA_PC;
                aluCtrl.srcB         = `SRCB_OFFSET;
            end
            stExecute: begin
                aluCtrl.aluOp        = classOp(curClass);
                aluCtrl.srcA         = `SRCA_REGA;
                aluCtrl.srcB         = `SRCB_REGB;
                pathCtrl.aluOutWrite = 1'b1;
            end
            stWriteback: begin
                regCtrl.regWrite  = 1'b1;
                regCtrl.regDst    = `DST_RD;
                regCtrl.writeData = `WD_ALUOUT;
            end
            stException: begin
                excCtrl.exCause = (curClass == clsInvalid) ? `EXC_INVALID : `EXC_OVERFLOW;
                if (step == '0) begin
                    excCtrl.epcWrite = 1'b1;
                end else begin
                    pathCtrl.pcWrite = 1'b1;
                    pathCtrl.pcSrc   = `PCSRC_EXCVEC;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/controlUnit.sv
module controlUnit (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::opcode_t   opcode,
    input  ctrlPkg::funct_t    funct,
    input  logic               overflow,
    output ctrlPkg::aluCtrl_t  aluCtrl,
    output ctrlPkg::pathCtrl_t pathCtrl,
    output ctrlPkg::regCtrl_t  regCtrl,
    output ctrlPkg::excCtrl_t  excCtrl
);

    import ctrlPkg::*;

    instrClass_t instrClass;
    instrClass_t curClass;
    ctrlState_t  state;
    step_t       step;

    instrDecoder instrDecoder_i (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer controlSequencer_i (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state),
        .step       (step),
        .curClass   (curClass)
    );

    controlEncoder controlEncoder_i (
        .state    (state),
        .step     (step),
        .curClass (curClass),
        .aluCtrl  (aluCtrl),
        .pathCtrl (pathCtrl),
        .regCtrl  (regCtrl),
        .excCtrl  (excCtrl)
    );

endmodule

//--- tests/clockGen.sv
module clockGen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod = 5;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

endmodule

//--- tests/controlUnitAssert.sv
`include "ctrl_defines.svh"

module controlUnitAssert (
    input logic               clk,
    input logic               reset,
    input ctrlPkg::opcode_t   opcode,
    input ctrlPkg::funct_t    funct,
    input logic               overflow,
    input ctrlPkg::aluCtrl_t  aluCtrl,
    input ctrlPkg::pathCtrl_t pathCtrl,
    input ctrlPkg::regCtrl_t  regCtrl,
    input ctrlPkg::excCtrl_t  excCtrl
);

    timeunit 1ns;
    timeprecision 100ps;

    import ctrlPkg::*;

    int resetErrs = 0;
    int fetchErrs = 0;
    int validErrs = 0;
    int ovfErrs = 0;
    int invalidErrs = 0;

    logic       fetchStart;
    logic       excVector;
    logic [2:0] fetchBits;
    logic       arithNow;
    logic       validNow;
    logic       arithPrev;
    logic       trapNow;
    funct_t     fnPrev;
    aluOp_t     expOp;

    assign fetchStart = pathCtrl.pcWrite && pathCtrl.pcSrc == `PCSRC_ALU;
    assign excVector  = pathCtrl.pcWrite && pathCtrl.pcSrc == `PCSRC_EXCVEC;
    assign fetchBits  = {pathCtrl.irWrite, pathCtrl.memRead, pathCtrl.pcWrite};
    assign arithNow   = opcode == `OPC_RTYPE && (funct == `FN_ADD || funct == `FN_SUB);
    assign validNow   = arithNow || (opcode == `OPC_RTYPE && (funct == `FN_AND || funct == `FN_SLT));
    assign trapNow    = overflow && arithPrev;

    // ALU operation for the funct seen in decode
    assign expOp = (fnPrev == `FN_SUB) ? `ALUOP_SUB :
                   (fnPrev == `FN_AND) ? `ALUOP_AND :
                   (fnPrev == `FN_SLT) ? `ALUOP_SLT : `ALUOP_ADD;

    always_ff @(posedge clk) begin
        fnPrev    <= funct;
        arithPrev <= arithNow;
    end

    resetQuiet: assert property (@(posedge clk) reset && $past(reset) |->
            !pathCtrl.pcWrite && !pathCtrl.irWrite && !regCtrl.regWrite && !excCtrl.epcWrite)
        else begin
            resetErrs++;
            $error("FAILED reset: pcWrite irWrite regWrite epcWrite expected 0000 actual %b%b%b%b",
                $sampled(pathCtrl.pcWrite), $sampled(pathCtrl.irWrite),
                $sampled(regCtrl.regWrite), $sampled(excCtrl.epcWrite));
        end

    firstFetch: assert property (@(posedge clk) $fell(reset) |=> fetchStart)
        else begin
            resetErrs++;
            $error("FAILED reset: first pcWrite expected 1 actual %b", $sampled(fetchStart));
        end

    fetchEntry: assert property (@(posedge clk) disable iff (reset)
            $rose(pathCtrl.irWrite) |-> fetchStart)
        else begin
            fetchErrs++;
            $error("FAILED fetch: pcWrite with irWrite rising expected 1 actual %b",
                $sampled(fetchStart));
        end

    // Three fetch steps, PC updated only in the first, then decode
    fetchSteps: assert property (@(posedge clk) disable iff (reset)
            fetchStart |-> fetchBits == 3'b111 ##1 fetchBits == 3'b110 [*2]
                ##1 fetchBits[2:1] == 2'b00)
        else begin
            fetchErrs++;
            $error("FAILED fetch: irWrite memRead pcWrite expected 111,110,110,00x actual %b",
                $sampled(fetchBits));
        end

    // PC plus four while the PC is written
    fetchAlu: assert property (@(posedge clk) disable iff (reset)
            fetchStart |-> aluCtrl == {`ALUOP_ADD, `SRCA_PC, `SRCB_FOUR})
        else begin
            fetchErrs++;
            $error("FAILED fetch: aluCtrl expected %b actual %b",
                {`ALUOP_ADD, `SRCA_PC, `SRCB_FOUR}, $sampled(aluCtrl));
        end

    decodeLoad: assert property (@(posedge clk) disable iff (reset)
            fetchStart |-> ##3 (pathCtrl.loadAB && pathCtrl.aluOutWrite))
        else begin
            fetchErrs++;
            $error("FAILED fetch: decode loadAB aluOutWrite expected 11 actual %b%b",
                $sampled(pathCtrl.loadAB), $sampled(pathCtrl.aluOutWrite));
        end

    validAlu: assert property (@(posedge clk) disable iff (reset)
            fetchStart ##3 validNow |=> aluCtrl == {expOp, `SRCA_REGA, `SRCB_REGB}
                && pathCtrl.aluOutWrite)
        else begin
            validErrs++;
            $error("FAILED valid: aluCtrl aluOutWrite expected %b actual %b",
                {$sampled(expOp), `SRCA_REGA, `SRCB_REGB, 1'b1},
                {$sampled(aluCtrl), $sampled(pathCtrl.aluOutWrite)});
        end

    validWrite: assert property (@(posedge clk) disable iff (reset)
            fetchStart ##3 validNow ##1 !trapNow |=> regCtrl == {1'b1, `DST_RD, `WD_ALUOUT})
        else begin
            validErrs++;
            $error("FAILED valid: regCtrl expected %b actual %b",
                {1'b1, `DST_RD, `WD_ALUOUT}, $sampled(regCtrl));
        end

    writeTiming: assert property (@(posedge clk) disable iff (reset)
            regCtrl.regWrite |-> $past(fetchStart, 5))
        else begin
            validErrs++;
            $error("FAILED valid: pcWrite five cycles before regWrite expected 1 actual 0");
        end

    ovfEpc: assert property (@(posedge clk) disable iff (reset)
            fetchStart ##3 arithNow ##1 overflow |=>
                excCtrl == {1'b1, `EXC_OVERFLOW} && !regCtrl.regWrite)
        else begin
            ovfErrs++;
            $error("FAILED overflow: epcWrite exCause regWrite expected %b actual %b",
                {1'b1, `EXC_OVERFLOW, 1'b0}, {$sampled(excCtrl), $sampled(regCtrl.regWrite)});
        end

    ovfVector: assert property (@(posedge clk) disable iff (reset)
            fetchStart ##3 arithNow ##1 overflow ##1 1'b1 |=> excVector && !regCtrl.regWrite)
        else begin
            ovfErrs++;
            $error("FAILED overflow: vector pcWrite regWrite expected 10 actual %b%b",
                $sampled(excVector), $sampled(regCtrl.regWrite));
        end

    invEpc: assert property (@(posedge clk) disable iff (reset)
            fetchStart ##3 !validNow |=> excCtrl == {1'b1, `EXC_INVALID} && !regCtrl.regWrite)
        else begin
            invalidErrs++;
            $error("FAILED invalid: epcWrite exCause regWrite expected %b actual %b",
                {1'b1, `EXC_INVALID, 1'b0}, {$sampled(excCtrl), $sampled(regCtrl.regWrite)});
        end

    invVector: assert property (@(posedge clk) disable iff (reset)
            fetchStart ##3 !validNow ##1 1'b1 |=> excVector && !regCtrl.regWrite)
        else begin
            invalidErrs++;
            $error("FAILED invalid: vector pcWrite regWrite expected 10 actual %b%b",
                $sampled(excVector), $sampled(regCtrl.regWrite));
        end

endmodule

bind controlUnit controlUnitAssert controlUnitAssert_i (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .funct    (funct),
    .overflow (overflow),
    .aluCtrl  (aluCtrl),
    .pathCtrl (pathCtrl),
    .regCtrl  (regCtrl),
    .excCtrl  (excCtrl)
);

//--- tests/controlUnitTb.sv
`include "ctrl_defines.svh"

module controlUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    import ctrlPkg::*;

    localparam int NumInstr    = 60;
    localparam int ResetCycles = 16;
    localparam int CycleLimit  = NumInstr * 7 + ResetCycles + 50;

    logic      clk;
    logic      reset;
    opcode_t   opcode;
    funct_t    funct;
    logic      overflow;
    aluCtrl_t  aluCtrl;
    pathCtrl_t pathCtrl;
    regCtrl_t  regCtrl;
    excCtrl_t  excCtrl;

    logic [31:0] rngState;
    logic        ovfBit;
    logic        ovfAtExec;
    logic        curValid;
    logic        curArith;
    logic        inFlight;
    logic        allDone;
    int          cycles;
    int          sincePc;
    int          doneCount;
    int          nValid;
    int          nOvf;
    int          nInvalid;
    int          failCount;

    clockGen clockGen_i (
        .clk (clk)
    );

    controlUnit controlUnit_i (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .aluCtrl  (aluCtrl),
        .pathCtrl (pathCtrl),
        .regCtrl  (regCtrl),
        .excCtrl  (excCtrl)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Moves a supported funct off its code
    function automatic funct_t unsupportedFunct(input funct_t fn);
        if (fn == `FN_ADD || fn == `FN_SUB || fn == `FN_AND || fn == `FN_SLT) begin
            return fn ^ 6'h01;
        end
        return fn;
    endfunction

    task automatic drawInstr();
        logic [31:0] r;
        rngState = xorshift32(rngState);
        r = rngState;
        curValid = (r[1:0] != 2'd0);
        curArith = curValid && !r[4];
        if (!curValid && r[2]) begin
            opcode <= r[13:8] | 6'h01;
            funct  <= r[21:16];
        end else if (!curValid) begin
            opcode <= `OPC_RTYPE;
            funct  <= unsupportedFunct(r[21:16]);
        end else begin
            opcode <= `OPC_RTYPE;
            case (r[4:3])
                2'd0: funct <= `FN_ADD;
                2'd1: funct <= `FN_SUB;
                2'd2: funct <= `FN_AND;
                default: funct <= `FN_SLT;
            endcase
        end
    endtask

    task automatic tallyInstr();
        if (!curValid) begin
            nInvalid++;
        end else if (curArith && ovfAtExec) begin
            nOvf++;
        end else begin
            nValid++;
        end
        doneCount++;
        allDone <= (doneCount >= NumInstr);
    endtask

    task automatic reportTest(input string name, input int runs, input int errs);
        if (runs == 0) begin
            $display("%s: no instruction of this kind was run", name);
            failCount++;
        end else if (errs != 0) begin
            $display("%s: %0d run, %0d assertion failures", name, runs, errs);
            failCount++;
        end else begin
            $display("%s: %0d run, ok", name, runs);
        end
    endtask

    // Each new instruction is issued as its fetch step 0 ends
    always @(posedge clk) begin
        rngState = xorshift32(rngState);
        ovfBit = rngState[7];
        overflow <= ovfBit;
        cycles <= cycles + 1;
        if (pathCtrl.pcWrite && pathCtrl.pcSrc == `PCSRC_ALU) begin
            if (inFlight) begin
                tallyInstr();
            end
            inFlight <= 1'b1;
            sincePc = 1;
            drawInstr();
        end else begin
            sincePc = sincePc + 1;
            if (sincePc == 4) begin
                ovfAtExec = ovfBit;
            end
        end
    end

    initial begin
        reset     = 1'b1;
        opcode    = `OPC_RTYPE;
        funct     = `FN_ADD;
        overflow  = 1'b0;
        rngState  = 32'd19566;
        ovfAtExec = 1'b0;
        curValid  = 1'b1;
        curArith  = 1'b1;
        inFlight  = 1'b0;
        allDone   = 1'b0;
        cycles    = 0;
        sincePc   = 0;
        doneCount = 0;
        nValid    = 0;
        nOvf      = 0;
        nInvalid  = 0;
        failCount = 0;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;
        while (!inFlight && cycles < CycleLimit) @(posedge clk);
        #1;
        reportTest("reset", 1, controlUnit_i.controlUnitAssert_i.resetErrs);
        while (!allDone && cycles < CycleLimit) @(posedge clk);
        @(posedge clk);
        #1;
        if (!allDone) begin
            $display("timeout: %0d of %0d instructions finished after %0d cycles",
                doneCount, NumInstr, cycles);
            $display("sim failed");
        end else begin
            reportTest("fetch", doneCount, controlUnit_i.controlUnitAssert_i.fetchErrs);
            reportTest("valid instructions", nValid, controlUnit_i.controlUnitAssert_i.validErrs);
            reportTest("overflow traps", nOvf, controlUnit_i.controlUnitAssert_i.ovfErrs);
            reportTest("invalid traps", nInvalid, controlUnit_i.controlUnitAssert_i.invalidErrs);
            $display("tests: 5, failed: %0d, instructions: %0d, cycles: %0d",
                failCount, doneCount, cycles);
            if (failCount == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
tests/clockGen.sv
tests/controlUnitAssert.sv
tests/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ctrlPkg.sv
      - hdl/instrDecoder.sv
      - hdl/controlSequencer.sv
      - hdl/controlEncoder.sv
      - hdl/controlUnit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/clockGen.sv
      - tests/controlUnitAssert.sv
      - tests/controlUnitTb.sv
